// ==== logic/dataflowPkg.sv ====
package dataflowPkg;

  // Operand and result widths
  localparam int OPERAND_W = 16;
  localparam int SUM_W     = OPERAND_W + 1;
  localparam int PROD_W    = 2 * OPERAND_W;

  // Depth of the operand branch buffer beside the multiplier
  localparam int SIDE_FIFO_SLOTS = 4;

  // One input item with a on the upper half of the word
  typedef struct packed {
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } operandPair_t;

  // Combined result leaving the join
  typedef struct packed {
    logic [SUM_W-1:0]  sum;
    logic [PROD_W-1:0] prod;
  } kernelResult_t;

endpackage

// ==== logic/elasticFifo.sv ====
module elasticFifo #(
  parameter type payload_t = logic [31:0],
  parameter int  NUM_SLOTS = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t inData,
  input  logic     inValid,
  output logic     inReady,
  output payload_t outData,
  output logic     outValid,
  input  logic     outReady
);

  // A single slot still keeps one pointer bit
  localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

  payload_t             mem [NUM_SLOTS];
  logic [PTR_W-1:0]     head;
  logic [PTR_W-1:0]     tail;
  logic [PTR_W-1:0]     headNext;
  logic [PTR_W-1:0]     tailNext;
  logic                 full;
  logic                 empty;
  logic                 writeEn;
  logic                 readEn;

  // A full buffer still takes an item when the head leaves on the same edge
  assign inReady  = ~full | outReady;
  assign outValid = ~empty;
  assign outData  = mem[head];

  assign writeEn = inValid & inReady;
  assign readEn  = outReady & ~empty;

  // Pointers wrap at the slot count, which need not be a power of two
  assign headNext = (head == PTR_W'(NUM_SLOTS - 1)) ? '0 : head + 1'b1;
  assign tailNext = (tail == PTR_W'(NUM_SLOTS - 1)) ? '0 : tail + 1'b1;

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[tail] <= inData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (writeEn) begin
        tail <= tailNext;
      end
      if (readEn) begin
        head <= headNext;
      end
    end
  end

  // Flags only move when the buffer fills or drains but never on both
  always_ff @(posedge clk) begin
    if (rst) begin
      full  <= 1'b0;
      empty <= 1'b1;
    end else if (writeEn && !readEn) begin
      empty <= 1'b0;
      if (tailNext == head) begin
        full <= 1'b1;
      end
    end else if (readEn && !writeEn) begin
      full <= 1'b0;
      if (headNext == tail) begin
        empty <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/eagerFork.sv ====
module eagerFork (
  input  logic                    clk,
  input  logic                    rst,
  input  dataflowPkg::operandPair_t inData,
  input  logic                    inValid,
  output logic                    inReady,
  output dataflowPkg::operandPair_t outData,
  output logic [1:0]              outValid,
  input  logic [1:0]              outReady
);

  // One bit per branch that has already taken the current item
  logic [1:0] sent;
  logic [1:0] done;
  logic [1:0] takeNow;

  // Both branches see the same payload
  assign outData = inData;

  assign outValid = {2{inValid}} & ~sent;
  assign takeNow  = outValid & outReady;

  // A branch is finished once it took the item earlier or takes it now
  assign done    = sent | outReady;
  assign inReady = &done;

  always_ff @(posedge clk) begin
    if (rst) begin
      sent <= 2'b00;
    end else if (inValid && inReady) begin
      // Item fully delivered so the next one starts fresh
      sent <= 2'b00;
    end else begin
      sent <= sent | takeNow;
    end
  end

endmodule

// ==== logic/pipeMultiplier.sv ====
module pipeMultiplier (
  input  logic                             clk,
  input  logic                             rst,
  input  dataflowPkg::operandPair_t        inData,
  input  logic                             inValid,
  output logic                             inReady,
  output logic [dataflowPkg::PROD_W-1:0]   outProd,
  output logic                             outValid,
  input  logic                             outReady
);

  // Stage 1 holds operands and stage 2 the product
  dataflowPkg::operandPair_t             s1Data;
  logic                                  s1Valid;
  logic [dataflowPkg::PROD_W-1:0]        s2Prod;
  logic                                  s2Valid;
  logic [dataflowPkg::PROD_W-1:0]        product;
  logic                                  advance;

  // Whole pipe moves as one, so latency never changes
  assign advance = ~s2Valid | outReady;
  assign inReady = advance;

  assign product = dataflowPkg::PROD_W'(s1Data.a) * dataflowPkg::PROD_W'(s1Data.b);

  assign outProd  = s2Prod;
  assign outValid = s2Valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end else if (advance) begin
      s1Valid <= inValid;
      s2Valid <= s1Valid;
    end
  end

  // Operands and product shift on the same advance as their valid bits
  always_ff @(posedge clk) begin
    if (advance) begin
      s1Data <= inData;
      s2Prod <= product;
    end
  end

endmodule

// ==== logic/resultJoin.sv ====
module resultJoin (
  input  logic                           clk,
  input  logic                           rst,
  input  dataflowPkg::operandPair_t      opData,
  input  logic                           opValid,
  output logic                           opReady,
  input  logic [dataflowPkg::PROD_W-1:0] prodData,
  input  logic                           prodValid,
  output logic                           prodReady,
  output dataflowPkg::kernelResult_t     outData,
  output logic                           outValid,
  input  logic                           outReady
);

  logic                          canLoad;
  logic                          fire;
  logic [dataflowPkg::SUM_W-1:0] sum;

  // Output register is free or drains this cycle
  assign canLoad = ~outValid | outReady;

  // Each side waits for its partner
  assign opReady   = prodValid & canLoad;
  assign prodReady = opValid & canLoad;
  assign fire      = opValid & prodValid & canLoad;

  assign sum = dataflowPkg::SUM_W'(opData.a) + dataflowPkg::SUM_W'(opData.b);

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (fire) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      outData.sum  <= sum;
      outData.prod <= prodData;
    end
  end

endmodule

// ==== logic/dataflowKernel.sv ====
module dataflowKernel (
  input  logic                       clk,
  input  logic                       rst,
  input  dataflowPkg::operandPair_t  inData,
  input  logic                       inValid,
  output logic                       inReady,
  output dataflowPkg::kernelResult_t outData,
  output logic                       outValid,
  input  logic                       outReady
);

  // Fork outputs with branch 0 to the FIFO and branch 1 to the multiplier
  dataflowPkg::operandPair_t      forkData;
  logic [1:0]                     forkValid;
  logic [1:0]                     forkReady;

  // Operand branch after the FIFO
  dataflowPkg::operandPair_t      sideData;
  logic                           sideValid;
  logic                           sideReady;

  // Product branch
  logic [dataflowPkg::PROD_W-1:0] prodData;
  logic                           prodValid;
  logic                           prodReady;

  eagerFork forkInst (
    .clk      (clk),
    .rst      (rst),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (forkData),
    .outValid (forkValid),
    .outReady (forkReady)
  );

  elasticFifo #(
    .payload_t (dataflowPkg::operandPair_t),
    .NUM_SLOTS (dataflowPkg::SIDE_FIFO_SLOTS)
  ) sideFifo (
    .clk      (clk),
    .rst      (rst),
    .inData   (forkData),
    .inValid  (forkValid[0]),
    .inReady  (forkReady[0]),
    .outData  (sideData),
    .outValid (sideValid),
    .outReady (sideReady)
  );

  pipeMultiplier mulInst (
    .clk      (clk),
    .rst      (rst),
    .inData   (forkData),
    .inValid  (forkValid[1]),
    .inReady  (forkReady[1]),
    .outProd  (prodData),
    .outValid (prodValid),
    .outReady (prodReady)
  );

  resultJoin joinInst (
    .clk       (clk),
    .rst       (rst),
    .opData    (sideData),
    .opValid   (sideValid),
    .opReady   (sideReady),
    .prodData  (prodData),
    .prodValid (prodValid),
    .prodReady (prodReady),
    .outData   (outData),
    .outValid  (outValid),
    .outReady  (outReady)
  );

endmodule

// ==== verif/kernelTb.sv ====
module kernelTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STREAM_COUNT   = 200;
  localparam int RANDOM_COUNT   = 500;
  localparam int STALL_COUNT    = 20;
  localparam int CORNER_COUNT   = 40;
  localparam int STALL_CYCLES   = 30;
  localparam int PLANNED_ITEMS  = STREAM_COUNT + RANDOM_COUNT + STALL_COUNT + CORNER_COUNT;
  localparam int WATCHDOG_CYCLES = PLANNED_ITEMS * 20 + 200;

  logic                       clk;
  logic                       rst;
  dataflowPkg::operandPair_t  inData;
  logic                       inValid;
  logic                       inReady;
  dataflowPkg::kernelResult_t outData;
  logic                       outValid;
  logic                       outReady;

  integer                     seed;
  dataflowPkg::kernelResult_t expQ[$];
  dataflowPkg::kernelResult_t expected;
  dataflowPkg::kernelResult_t heldData;
  logic                       holdPending;
  logic                       sawBackPressure;
  logic                       checkContinuous;
  int                         streamBase;
  int                         streamLen;
  int                         recvCount;
  int                         errorCount;
  int                         passCount;
  int                         failCount;
  int                         startErr;

  dataflowKernel dut_i (
    .clk      (clk),
    .rst      (rst),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Expected 17-bit sum and 32-bit product of the unsigned operands
  function automatic dataflowPkg::kernelResult_t expectedResult(
    input dataflowPkg::operandPair_t p
  );
    dataflowPkg::kernelResult_t r;
    r.sum  = {1'b0, p.a} + {1'b0, p.b};
    r.prod = {16'h0000, p.a} * {16'h0000, p.b};
    return r;
  endfunction

  function automatic bit chance(input int pct);
    int r;
    r = int'($unsigned($random(seed)) % 32'd100);
    return r < pct;
  endfunction

  // Maps low bits onto zero, max, one or the raw value
  function automatic logic [15:0] cornerOperand(input logic [15:0] v);
    case (v[1:0])
      2'd0:    return 16'h0000;
      2'd1:    return 16'hFFFF;
      2'd2:    return 16'h0001;
      default: return v;
    endcase
  endfunction

  function automatic dataflowPkg::operandPair_t randomPair(input bit corners);
    dataflowPkg::operandPair_t p;
    logic [31:0]               r;
    r = $random(seed);
    p.a = r[31:16];
    p.b = r[15:0];
    if (corners) begin
      p.a = cornerOperand(p.a);
      p.b = cornerOperand(p.b);
    end
    return p;
  endfunction

  // Drives one test and returns once every accepted item has come out
  task automatic runStream(input int count, input int validPct, input int readyPct,
                           input int stallCycles, input bit corners);
    int sent;
    int cycle;
    int target;
    sent = 0;
    cycle = 0;
    target = recvCount + count;
    forever begin
      @(posedge clk);
      if (inValid && inReady) sent++;
      // An offered item stays put until it is taken
      if (!(inValid && !inReady)) begin
        if (sent < count && chance(validPct)) begin
          inValid <= 1'b1;
          inData  <= randomPair(corners);
        end else begin
          inValid <= 1'b0;
        end
      end
      if (cycle < stallCycles) outReady <= 1'b0;
      else outReady <= chance(readyPct);
      cycle++;
      @(negedge clk);
      if (recvCount >= target) break;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    int newErrors;
    assert (expQ.size() == 0) else begin
      $display("Test %s left %0d accepted inputs without a result", name, expQ.size());
      errorCount++;
    end
    newErrors = errorCount - errorsBefore;
    if (newErrors == 0) begin
      passCount++;
      $display("Test %s: pass", name);
    end else begin
      failCount++;
      $display("Test %s: fail with %0d errors", name, newErrors);
    end
  endtask

  // Scoreboard and protocol checks sampled on the edge before any update lands
  always @(posedge clk) begin
    if (!rst) begin
      if (inValid && inReady) expQ.push_back(expectedResult(inData));
      if (inValid && !inReady) sawBackPressure = 1'b1;
      if (holdPending) begin
        assert (outValid && outData == heldData) else begin
          $display("[ERROR] t=%0t: output moved during stall, held %h now %h valid %b",
                   $time, heldData, outData, outValid);
          errorCount++;
        end
      end
      if (checkContinuous && recvCount > streamBase && recvCount < streamBase + streamLen) begin
        assert (outValid) else begin
          $display("[ERROR] t=%0t: gap in output stream after %0d results",
                   $time, recvCount - streamBase);
          errorCount++;
        end
      end
      holdPending = outValid && !outReady;
      heldData    = outData;
      if (outValid && outReady) begin
        assert (expQ.size() > 0) else begin
          $display("A result came out with no matching input at time %0t", $time);
          errorCount++;
        end
        if (expQ.size() > 0) begin
          expected = expQ.pop_front();
          assert (outData == expected) else begin
            $display("[ERROR] t=%0t: result %0d expected sum %h prod %h, got sum %h prod %h",
                     $time, recvCount, expected.sum, expected.prod,
                     outData.sum, outData.prod);
            errorCount++;
          end
        end
        recvCount++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed = 32'h756d;
    rst = 1'b1;
    inValid = 1'b0;
    inData = '0;
    outReady = 1'b0;
    holdPending = 1'b0;
    sawBackPressure = 1'b0;
    checkContinuous = 1'b0;
    streamBase = 0;
    streamLen = 0;
    recvCount = 0;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    startErr = errorCount;
    assert (!outValid && inReady) else begin
      $display("[ERROR] t=%0t: after reset outValid=%b inReady=%b, expected 0 and 1",
               $time, outValid, inReady);
      errorCount++;
    end
    reportTest("reset state", startErr);

    startErr = errorCount;
    streamBase = recvCount;
    streamLen = STREAM_COUNT;
    checkContinuous = 1'b1;
    runStream(STREAM_COUNT, 100, 100, 0, 1'b0);
    checkContinuous = 1'b0;
    reportTest("streaming", startErr);

    startErr = errorCount;
    runStream(RANDOM_COUNT, 50, 50, 0, 1'b0);
    reportTest("random back-pressure", startErr);

    startErr = errorCount;
    sawBackPressure = 1'b0;
    runStream(STALL_COUNT, 100, 100, STALL_CYCLES, 1'b0);
    assert (sawBackPressure) else begin
      $display("Input ready never dropped while the output was stalled");
      errorCount++;
    end
    reportTest("stall holding", startErr);

    startErr = errorCount;
    runStream(CORNER_COUNT, 100, 70, 0, 1'b1);
    reportTest("extreme operands", startErr);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
logic/dataflowPkg.sv
logic/elasticFifo.sv
logic/eagerFork.sv
logic/pipeMultiplier.sv
logic/resultJoin.sv
logic/dataflowKernel.sv
verif/kernelTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kernelTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := logic/dataflowPkg.sv logic/elasticFifo.sv logic/eagerFork.sv \
        logic/pipeMultiplier.sv logic/resultJoin.sv logic/dataflowKernel.sv \
        verif/kernelTb.sv
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJ_DIR)
